// ==== vlog.f ====
+incdir+hw
hw/uart_pkg.sv
hw/sync_fifo.sv
hw/uart_rx_decoder.sv
hw/uart_tx_encoder.sv
hw/wb_uart_regs.sv
hw/uart_top.sv
bench/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the uart testbench with verilator, run it and scan the log for a failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module uart_tb \
    -Mdir obj_dir -o uart_tb_sim > build.log 2>&1 &&
./obj_dir/uart_tb_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failures"
exit 0

// ==== bench/uart_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_tb;

    localparam int clk_period    = 8;
    // tx frames in tests 2 and 3, rx frames in 4 and 5, at most 40 writes in test 6
    localparam int frames_total  = 6 + 4 + 3 + 9 + 40;
    localparam int watchdog_time = (frames_total * 11 + 3000) * clk_period;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        rx;
    logic        tx;
    logic        rx_drv;     // serial driver output
    logic        loopback;   // ties tx back to rx

    integer      seed = 32'ha798_67c8;
    int          errors = 0;
    int          accesses = 0;
    int          frames_seen = 0;
    logic [7:0]  tx_seen[$];       // bytes captured from the tx line
    logic [7:0]  tx_expected[$];

    assign rx = loopback ? tx : rx_drv;

    uart_top dut (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .rx(rx), .tx(tx)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    endtask

    function automatic logic [7:0] next_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // one classic cycle, adr and data stay put until the ack edge has passed
    task automatic wb_access(input logic we, input logic [1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        @(negedge clk);
        while (wb_ack !== 1'b1 && waited < 16)
        begin
            @(negedge clk);
            waited++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        accesses++;
        if (wb_ack !== 1'b1)
        begin
            errors++;
            $display("no ack from the bus slave for word address %0d", adr);
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    // start, d0..d7, even parity, stop, then one idle cycle
    task automatic send_frame(input logic [7:0] b, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        int          i;
        bits = {~bad_stop, (^b) ^ bad_parity, b, 1'b0};
        for (i = 0; i < 11; i++)
        begin
            @(negedge clk);
            rx_drv = bits[i];
        end
        @(negedge clk);
        rx_drv = 1'b1;
    endtask

    task automatic wait_tx_frames(input int n);
        int waited;
        waited = 0;
        while (tx_seen.size() < n && waited < n * 11 + 100)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx_seen.size() < n)
        begin
            errors++;
            $display("only %0d of %0d frames appeared on tx", tx_seen.size(), n);
        end
    endtask

    task automatic expect_line_idle(input int cycles);
        int lows;
        int i;
        lows = 0;
        for (i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            if (tx !== 1'b1)
                lows++;
        end
        if (lows != 0)
        begin
            errors++;
            $display("tx left the idle level in %0d of %0d cycles", lows, cycles);
        end
    endtask

    task automatic compare_tx_bytes();
        int i;
        if (tx_seen.size() != tx_expected.size())
            report_mismatch("tx frame count", 32'(tx_seen.size()), 32'(tx_expected.size()));
        for (i = 0; i < tx_seen.size() && i < tx_expected.size(); i++)
            if (tx_seen[i] !== tx_expected[i])
                report_mismatch("tx byte", 32'(tx_seen[i]), 32'(tx_expected[i]));
    endtask

    // captures each frame on tx and checks parity and stop
    initial
    begin : tx_monitor
        logic [7:0] b;
        logic       p;
        logic       s;
        int         i;
        forever
        begin
            @(negedge clk);
            if (!reset && tx === 1'b0)
            begin
                for (i = 0; i < 8; i++)
                begin
                    @(negedge clk);
                    b[i] = tx;   // lsb first
                end
                @(negedge clk);
                p = tx;
                @(negedge clk);
                s = tx;
                if (p !== ^b)
                    report_mismatch("tx parity", 32'(p), 32'(^b));
                if (s !== 1'b1)
                    report_mismatch("tx stop", 32'(s), 32'h1);
                tx_seen.push_back(b);
                frames_seen++;
            end
        end
    end

    task automatic after_reset();
        logic [31:0] rd;
        if (wb_ack !== 1'b0)
            report_mismatch("wb_ack", 32'(wb_ack), 32'h0);
        wb_read(`UART_ADDR_STATUS, rd);
        if (rd !== 32'h1)
            report_mismatch("wb_dat_r", rd, 32'h1);
        expect_line_idle(20);
    endtask

    task automatic transmit_order();
        logic [7:0] b;
        int         i;
        tx_seen.delete();
        tx_expected.delete();
        for (i = 0; i < 6; i++)
        begin
            b = next_byte();
            tx_expected.push_back(b);
            wb_write(`UART_ADDR_DATA, {24'h0, b});
        end
        wait_tx_frames(6);
        compare_tx_bytes();
    endtask

    task automatic loopback_echo();
        logic [7:0]  b;
        logic [31:0] rd;
        int          i;
        @(negedge clk);
        loopback = 1'b1;
        tx_seen.delete();
        tx_expected.delete();
        for (i = 0; i < 4; i++)
        begin
            b = next_byte();
            tx_expected.push_back(b);
            wb_write(`UART_ADDR_DATA, {24'h0, b});
        end
        wait_tx_frames(4);
        repeat (3) @(negedge clk);   // decoder samples the stop bit one cycle late
        for (i = 0; i < 4; i++)
        begin
            wb_read(`UART_ADDR_DATA, rd);
            if (rd !== {24'h0, tx_expected[i]})
                report_mismatch("wb_dat_r", rd, {24'h0, tx_expected[i]});
        end
        wb_read(`UART_ADDR_STATUS, rd);
        if (rd !== 32'h1)
            report_mismatch("wb_dat_r", rd, 32'h1);
        @(negedge clk);
        loopback = 1'b0;
    endtask

    task automatic receive_errors();
        logic [7:0]  b [3];
        logic [2:0]  err_exp;
        logic [31:0] rd;
        logic [31:0] exp;
        int          i;
        err_exp = 3'b011;   // bad parity, bad stop, then a good frame
        for (i = 0; i < 3; i++)
            b[i] = next_byte();
        send_frame(b[0], 1'b1, 1'b0);
        send_frame(b[1], 1'b0, 1'b1);
        send_frame(b[2], 1'b0, 1'b0);
        repeat (3) @(negedge clk);
        for (i = 0; i < 3; i++)
        begin
            exp = {23'h0, err_exp[i], b[i]};
            wb_read(`UART_ADDR_DATA, rd);
            if (rd !== exp)
                report_mismatch("wb_dat_r", rd, exp);
        end
    endtask

    task automatic receive_overflow();
        logic [7:0]  b [9];
        logic [31:0] rd;
        int          i;
        for (i = 0; i < 9; i++)
        begin
            b[i] = next_byte();
            send_frame(b[i], 1'b0, 1'b0);
        end
        repeat (3) @(negedge clk);
        wb_read(`UART_ADDR_STATUS, rd);
        if (rd !== 32'h4)
            report_mismatch("wb_dat_r", rd, 32'h4);
        for (i = 0; i < 8; i++)
        begin
            wb_read(`UART_ADDR_DATA, rd);
            if (rd !== {24'h0, b[i]})
                report_mismatch("wb_dat_r", rd, {24'h0, b[i]});
        end
        wb_read(`UART_ADDR_STATUS, rd);
        if (rd !== 32'h5)
            report_mismatch("wb_dat_r", rd, 32'h5);
        wb_write(`UART_ADDR_STATUS, 32'h4);
        wb_read(`UART_ADDR_STATUS, rd);
        if (rd !== 32'h1)
            report_mismatch("wb_dat_r", rd, 32'h1);
    endtask

    // write until the sticky tx overflow shows, the last write is the dropped one
    task automatic transmit_overflow();
        logic [7:0]  b;
        logic [31:0] status;
        logic        full_seen;
        int          n;
        tx_seen.delete();
        tx_expected.delete();
        full_seen = 1'b0;
        status    = 32'h0;
        n         = 0;
        while (status[3] !== 1'b1 && n < 40)
        begin
            b = next_byte();
            tx_expected.push_back(b);
            wb_write(`UART_ADDR_DATA, {24'h0, b});
            wb_read(`UART_ADDR_STATUS, status);
            if (status[1] === 1'b1)
                full_seen = 1'b1;
            n++;
        end
        if (status[3] !== 1'b1)
        begin
            errors++;
            $display("tx_overflow never set after %0d writes", n);
        end
        else
            void'(tx_expected.pop_back());
        if (!full_seen)
        begin
            errors++;
            $display("tx_full was never reported before the overflow");
        end
        wait_tx_frames(tx_expected.size());
        expect_line_idle(13);
        wb_read(`UART_ADDR_STATUS, status);
        if (status !== 32'h9)
            report_mismatch("wb_dat_r", status, 32'h9);
        compare_tx_bytes();
        wb_write(`UART_ADDR_STATUS, 32'h8);
        wb_read(`UART_ADDR_STATUS, status);
        if (status !== 32'h1)
            report_mismatch("wb_dat_r", status, 32'h1);
    endtask

    initial
    begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_w = 32'h0;
        rx_drv   = 1'b1;
        loopback = 1'b0;
        reset    = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        after_reset();
        transmit_order();
        loopback_echo();
        receive_errors();
        receive_overflow();
        transmit_overflow();
        $display("errors %0d, bus accesses %0d, tx frames %0d", errors, accesses, frames_seen);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #(watchdog_time);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/uart_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_top
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        rx,
    output logic        tx
);
    import uart_pkg::*;

    rx_entry_t                  rx_in;
    rx_entry_t                  rx_head;
    logic                       rx_valid;
    logic                       rx_err;
    logic [`UART_DATA_BITS-1:0] rx_char;
    logic                       rx_push;
    logic                       rx_pop;
    logic                       rx_empty;
    logic                       rx_overflow;
    logic                       tx_push;
    logic [`UART_DATA_BITS-1:0] tx_byte;
    logic [`UART_DATA_BITS-1:0] tx_head;
    logic                       tx_pop;
    logic                       tx_empty;
    logic                       tx_full;
    logic                       tx_overflow;

    // errors are queued too, flagged, so the cpu sees them in order
    assign rx_push    = rx_valid || rx_err;
    assign rx_in.err  = rx_err;
    assign rx_in.data = rx_char;

    wb_uart_regs u_regs (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .rx_head(rx_head), .rx_empty(rx_empty), .rx_overflow(rx_overflow), .rx_pop(rx_pop),
        .tx_full(tx_full), .tx_overflow(tx_overflow), .tx_push(tx_push), .tx_byte(tx_byte)
    );

    // a full rx fifo is only reported through overflow
    sync_fifo #(.payload_t(rx_entry_t), .depth(`UART_RX_DEPTH)) u_rx_fifo (
        .clk(clk), .reset(reset), .push(rx_push), .push_data(rx_in), .pop(rx_pop),
        .pop_data(rx_head), .empty(rx_empty), .full(), .overflow(rx_overflow)
    );

    sync_fifo #(.payload_t(logic [`UART_DATA_BITS-1:0]), .depth(`UART_TX_DEPTH)) u_tx_fifo (
        .clk(clk), .reset(reset), .push(tx_push), .push_data(tx_byte), .pop(tx_pop),
        .pop_data(tx_head), .empty(tx_empty), .full(tx_full), .overflow(tx_overflow)
    );

    uart_rx_decoder u_rx (
        .clk(clk), .reset(reset), .rx(rx),
        .rx_valid(rx_valid), .rx_err(rx_err), .rx_data(rx_char)
    );

    uart_tx_encoder u_tx (
        .clk(clk), .reset(reset), .fifo_empty(tx_empty), .fifo_data(tx_head),
        .fifo_pop(tx_pop), .tx(tx)
    );

endmodule

`default_nettype wire

// ==== hw/wb_uart_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module wb_uart_regs
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [1:0]                 wb_adr,       // word address
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,     // valid while ack is high
    output logic                       wb_ack,
    input  uart_pkg::rx_entry_t        rx_head,
    input  logic                       rx_empty,
    input  logic                       rx_overflow,
    output logic                       rx_pop,
    input  logic                       tx_full,
    input  logic                       tx_overflow,
    output logic                       tx_push,
    output logic [`UART_DATA_BITS-1:0] tx_byte
);
    logic        req;
    logic        is_data;
    logic        is_status;
    logic        status_wr;
    logic        rx_ovf_q;   // sticky rx overflow
    logic        tx_ovf_q;   // sticky tx overflow
    logic [31:0] rd_data;

    assign req       = wb_cyc && wb_stb;
    assign is_data   = (wb_adr == `UART_ADDR_DATA);
    assign is_status = (wb_adr == `UART_ADDR_STATUS);

    // one ack per access, low again next cycle even if stb stays high
    always_ff @(posedge clk)
    begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= req && !wb_ack;
    end

    // strobes fire in the ack cycle, master holds adr and data until then
    assign tx_push   = wb_ack && wb_we && is_data;
    assign tx_byte   = wb_dat_w[`UART_DATA_BITS-1:0];
    assign rx_pop    = wb_ack && !wb_we && is_data && !rx_empty;
    assign status_wr = wb_ack && wb_we && is_status;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_ovf_q <= 1'b0;
            tx_ovf_q <= 1'b0;
        end
        else
        begin
            if (rx_overflow)
                rx_ovf_q <= 1'b1;   // a new overflow wins over a clear
            else if (status_wr && wb_dat_w[2])
                rx_ovf_q <= 1'b0;
            if (tx_overflow)
                tx_ovf_q <= 1'b1;
            else if (status_wr && wb_dat_w[3])
                tx_ovf_q <= 1'b0;
        end
    end

    always_comb
    begin
        rd_data = '0;
        if (is_data && !rx_empty)
            rd_data = {{(31 - `UART_DATA_BITS){1'b0}}, rx_head.err, rx_head.data};
        else if (is_status)
            rd_data = {28'b0, tx_ovf_q, rx_ovf_q, tx_full, rx_empty};
    end

    assign wb_dat_r = wb_ack ? rd_data : '0;

    // ack only answers a request seen in the previous cycle, never twice in a row
    assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(req) && !$past(wb_ack));

endmodule

`default_nettype wire

// ==== hw/uart_tx_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_tx_encoder
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fifo_empty,
    input  logic [`UART_DATA_BITS-1:0] fifo_data,   // head byte of the transmit fifo
    output logic                       fifo_pop,
    output logic                       tx           // registered serial line
);
    import uart_pkg::*;

    localparam int idx_w = $clog2(`UART_DATA_BITS);

    tx_state_t                  state_q;
    logic [idx_w-1:0]           bit_idx;    // data bit now on the line
    logic [`UART_DATA_BITS-1:0] byte_q;
    logic                       parity_q;

    // a new byte can be taken when idle or during the stop bit
    assign fifo_pop = ((state_q == txs_idle) || (state_q == txs_stop)) && !fifo_empty;

    always_ff @(posedge clk)
    begin
        if (fifo_pop)
        begin
            byte_q   <= fifo_data;
            parity_q <= ^fifo_data;   // even parity bit
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q <= txs_idle;
            bit_idx <= '0;
            tx      <= 1'b1;
        end
        else
        begin
            case (state_q)
                txs_idle, txs_stop:
                begin
                    if (!fifo_empty)
                    begin
                        state_q <= txs_start;
                        tx      <= 1'b0;
                    end
                    else
                    begin
                        state_q <= txs_idle;
                        tx      <= 1'b1;
                    end
                end
                txs_start:
                begin
                    state_q <= txs_data;
                    bit_idx <= '0;
                    tx      <= byte_q[0];   // lsb first
                end
                txs_data:
                begin
                    if (bit_idx == idx_w'(`UART_DATA_BITS - 1))
                    begin
                        state_q <= txs_parity;
                        tx      <= parity_q;
                    end
                    else
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        tx      <= byte_q[bit_idx + 1'b1];
                    end
                end
                txs_parity:
                begin
                    state_q <= txs_stop;
                    tx      <= 1'b1;
                end
                default:
                begin
                    state_q <= txs_idle;
                    tx      <= 1'b1;
                end
            endcase
        end
    end

    // every pop puts a start bit on the line in the next cycle
    assert property (@(posedge clk) disable iff (reset) fifo_pop |=> !tx);

endmodule

`default_nettype wire

// ==== hw/uart_rx_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_params.svh"

module uart_rx_decoder
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       rx,        // serial line, sampled once per bit
    output logic                       rx_valid,  // good character, one cycle
    output logic                       rx_err,    // parity or stop error, one cycle
    output logic [`UART_DATA_BITS-1:0] rx_data
);
    import uart_pkg::*;

    rx_state_t                  state_q;
    rx_state_t                  state_d;
    logic [`UART_DATA_BITS-1:0] data_q;   // bits shifted in so far
    logic [`UART_DATA_BITS-1:0] data_d;

    assign rx_data = data_q;

    always_comb
    begin
        state_d  = state_q;
        data_d   = data_q;
        rx_valid = 1'b0;
        rx_err   = 1'b0;
        case (state_q)
            rxs_wait_idle:
            begin
                if (rx)
                    state_d = rxs_idle;
            end
            rxs_idle:
            begin
                if (!rx)
                    state_d = rxs_d0;   // start bit seen
            end
            rxs_d0:
            begin
                data_d[0] = rx;
                state_d   = rxs_d1;
            end
            rxs_d1:
            begin
                data_d[1] = rx;
                state_d   = rxs_d2;
            end
            rxs_d2:
            begin
                data_d[2] = rx;
                state_d   = rxs_d3;
            end
            rxs_d3:
            begin
                data_d[3] = rx;
                state_d   = rxs_d4;
            end
            rxs_d4:
            begin
                data_d[4] = rx;
                state_d   = rxs_d5;
            end
            rxs_d5:
            begin
                data_d[5] = rx;
                state_d   = rxs_d6;
            end
            rxs_d6:
            begin
                data_d[6] = rx;
                state_d   = rxs_d7;
            end
            rxs_d7:
            begin
                data_d[7] = rx;
                state_d   = rxs_parity;
            end
            rxs_parity:
            begin
                // even parity: xor of data and parity bit must be 0
                if (rx ^ (^data_q))
                    state_d = rxs_error;
                else
                    state_d = rxs_success;
            end
            rxs_success:
            begin
                if (rx)
                begin
                    rx_valid = 1'b1;
                    state_d  = rxs_idle;   // ready for a back-to-back frame
                end
                else
                    state_d = rxs_error;   // stop bit low
            end
            rxs_error:
            begin
                rx_err  = 1'b1;
                state_d = rxs_idle;
            end
            default:
                state_d = rxs_wait_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state_q <= rxs_wait_idle;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk)
    begin
        data_q <= data_d;
    end

    // a result is one pulse of either kind, then quiet for at least a cycle
    assert property (@(posedge clk) disable iff (reset)
        (rx_valid || rx_err) |-> !(rx_valid && rx_err) ##1 !(rx_valid || rx_err));

endmodule

`default_nettype wire

// ==== hw/sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_fifo
#(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 8
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,   // head entry, no read latency
    output logic     empty,
    output logic     full,
    output logic     overflow    // push refused this cycle
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(depth));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign overflow = push && full;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    assert property (@(posedge clk) disable iff (reset) count <= cnt_w'(depth));

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
`default_nettype none
`include "uart_params.svh"

package uart_pkg;

    // receive states, one per line bit after the start bit
    typedef enum logic [3:0] {
        rxs_wait_idle = 4'd0,   // line must go high once after reset
        rxs_idle      = 4'd1,   // waiting for a start bit
        rxs_d0        = 4'd2,
        rxs_d1        = 4'd3,
        rxs_d2        = 4'd4,
        rxs_d3        = 4'd5,
        rxs_d4        = 4'd6,
        rxs_d5        = 4'd7,
        rxs_d6        = 4'd8,
        rxs_d7        = 4'd9,
        rxs_parity    = 4'd10,
        rxs_success   = 4'd11,  // stop bit cycle with good parity
        rxs_error     = 4'd12
    } rx_state_t;

    // transmit states, named after the bit currently on the line
    typedef enum logic [2:0] {
        txs_idle   = 3'd0,
        txs_start  = 3'd1,
        txs_data   = 3'd2,
        txs_parity = 3'd3,
        txs_stop   = 3'd4
    } tx_state_t;

    // err sits above the character so a 9-bit read maps straight to bit 8
    typedef struct packed {
        logic                       err;
        logic [`UART_DATA_BITS-1:0] data;
    } rx_entry_t;

endpackage

`default_nettype wire

// ==== hw/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// character width, one line bit per clk
`define UART_DATA_BITS 8

// fifo depths in entries
`define UART_RX_DEPTH 8
`define UART_TX_DEPTH 8

// wishbone word addresses
`define UART_ADDR_DATA   2'd0
`define UART_ADDR_STATUS 2'd1

`endif
